//--- design/daq_pkg.sv
`default_nettype none

package daq_pkg;

    // ########################################
    // Channels and words
    // ########################################
    localparam int NUM_ADC  = 4;
    localparam int SAMPLE_W = 16;
    localparam int SEQ_W    = 8;
    localparam int LANES    = 4;                        // Link lanes, one nibble per cycle
    localparam int NIBBLES  = SAMPLE_W / LANES;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [SEQ_W-1:0]    seq_t;

    // ########################################
    // SPI timing
    // ########################################
    localparam int SCLK_DIV   = 4;
    localparam int SCLK_HIGH  = SCLK_DIV / 2;           // SCLK is high in the first half period
    localparam int MISO_PHASE = 3;                      // Output register plus two sync flops
    localparam sample_t CONV_CMD = 16'hC3A0;

    // ########################################
    // Framing and credits
    // ########################################
    localparam logic [7:0] SYNC_BYTE = 8'hA5;
    localparam int FRAME_WORDS    = 5;
    localparam int BUILDER_DEPTH  = 8;
    localparam int LINK_BUF_DEPTH = 2;

    localparam int PH_W        = $clog2(SCLK_DIV);
    localparam int BIT_W       = $clog2(SAMPLE_W);
    localparam int CH_W        = $clog2(NUM_ADC);
    localparam int NIB_CNT_W   = $clog2(NIBBLES);
    localparam int WORD_CNT_W  = $clog2(FRAME_WORDS);
    localparam int FIFO_AW     = $clog2(BUILDER_DEPTH);
    localparam int GROUP_W     = $clog2(BUILDER_DEPTH / NUM_ADC + 1);
    localparam int CAP_CRED_W  = $clog2(BUILDER_DEPTH + 1);
    localparam int LB_AW       = $clog2(LINK_BUF_DEPTH);
    localparam int LINK_CRED_W = $clog2(LINK_BUF_DEPTH + 1);

endpackage

`default_nettype wire

//--- design/word_credit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface word_credit_if;

    logic             valid;                            // One word per cycle, never refused
    daq_pkg::sample_t data;
    logic             last;                             // Closes a group of words
    logic             credit;                           // One pulse per freed receiver slot

    modport sender (output valid, output data, output last, input credit);
    modport receiver (input valid, input data, input last, output credit);

endinterface

`default_nettype wire

//--- design/pin.sv
`timescale 1ns/1ps
`default_nettype none

module pin (
    input  wire                          clk,
    input  wire                          rst_n,

    output logic [daq_pkg::LANES-1:0]    com_txd_p,
    output logic [daq_pkg::LANES-1:0]    com_txd_n,
    input  wire                          com_rxf,
    output logic                         com_txf,

    input  wire  [daq_pkg::NUM_ADC-1:0]  adc_miso_p,
    input  wire  [daq_pkg::NUM_ADC-1:0]  adc_miso_n,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_cs_p,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_cs_n,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_mosi_p,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_mosi_n,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_sclk_p,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_sclk_n,

    input  wire  [daq_pkg::NUM_ADC-1:0]  cs,
    input  wire  [daq_pkg::NUM_ADC-1:0]  sclk,
    input  wire  [daq_pkg::NUM_ADC-1:0]  mosi,
    input  wire  [daq_pkg::LANES-1:0]    txd,
    input  wire                          txf,
    output logic                         fire,
    output logic [daq_pkg::NUM_ADC-1:0]  miso
);

    logic [daq_pkg::LANES-1:0]   txd_q;
    logic                        txf_q;
    logic [daq_pkg::NUM_ADC-1:0] cs_q;
    logic [daq_pkg::NUM_ADC-1:0] sclk_q;
    logic [daq_pkg::NUM_ADC-1:0] mosi_q;

    logic [daq_pkg::NUM_ADC-1:0] miso_diff_ok;
    logic [daq_pkg::NUM_ADC-1:0] miso_s1;
    logic [daq_pkg::NUM_ADC-1:0] miso_s2;
    logic                        fire_s1;
    logic                        fire_s2;

    // ########################################
    // Output pairs
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txd_q  <= '0;
            txf_q  <= 1'b0;
            cs_q   <= '1;                               // ADCs deselected
            sclk_q <= '0;
            mosi_q <= '0;
        end else begin
            txd_q  <= txd;
            txf_q  <= txf;
            cs_q   <= cs;
            sclk_q <= sclk;
            mosi_q <= mosi;
        end
    end

    assign com_txd_p  = txd_q;
    assign com_txd_n  = ~txd_q;
    assign com_txf    = txf_q;
    assign adc_cs_p   = cs_q;
    assign adc_cs_n   = ~cs_q;
    assign adc_sclk_p = sclk_q;
    assign adc_sclk_n = ~sclk_q;
    assign adc_mosi_p = mosi_q;
    assign adc_mosi_n = ~mosi_q;

    // ########################################
    // Input synchronizers
    // ########################################
    // A pair with equal legs carries no valid level, so the first flop keeps its value
    assign miso_diff_ok = adc_miso_p ^ adc_miso_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miso_s1 <= '0;
            miso_s2 <= '0;
            fire_s1 <= 1'b0;
            fire_s2 <= 1'b0;
        end else begin
            miso_s1 <= (adc_miso_p & miso_diff_ok) | (miso_s1 & ~miso_diff_ok);
            miso_s2 <= miso_s1;
            fire_s1 <= com_rxf;
            fire_s2 <= fire_s1;
        end
    end

    assign fire = fire_s2;
    assign miso = miso_s2;

endmodule

`default_nettype wire

//--- design/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          fire,
    input  wire  [daq_pkg::NUM_ADC-1:0]  miso,
    output logic [daq_pkg::NUM_ADC-1:0]  cs,
    output logic [daq_pkg::NUM_ADC-1:0]  sclk,
    output logic [daq_pkg::NUM_ADC-1:0]  mosi,
    word_credit_if.sender                out
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_SHIFT,
        ST_SEND
    } state_t;

    state_t                                    state;
    logic [daq_pkg::PH_W-1:0]                  ph;
    logic [daq_pkg::BIT_W-1:0]                 bit_cnt;
    logic [daq_pkg::CH_W-1:0]                  ch;
    logic [daq_pkg::CAP_CRED_W-1:0]            credits;
    logic                                      fire_q;
    daq_pkg::sample_t                          mosi_sr;
    daq_pkg::sample_t [daq_pkg::NUM_ADC-1:0]   samples;

    logic fire_rise;
    logic accept;
    logic ph_end;
    logic spi_active;
    logic send;

    assign fire_rise  = fire & ~fire_q;
    assign accept     = fire_rise && (state == ST_IDLE) && (credits >= daq_pkg::NUM_ADC);
    assign ph_end     = ph == daq_pkg::PH_W'(daq_pkg::SCLK_DIV - 1);
    assign spi_active = (state == ST_SETUP) || (state == ST_SHIFT);
    assign send       = state == ST_SEND;

    // All four ADCs run in lockstep off the same strobes
    assign cs   = {daq_pkg::NUM_ADC{~spi_active}};
    assign sclk = {daq_pkg::NUM_ADC{(state == ST_SHIFT) && (ph < daq_pkg::SCLK_HIGH)}};
    assign mosi = {daq_pkg::NUM_ADC{spi_active & mosi_sr[daq_pkg::SAMPLE_W-1]}};

    assign out.valid = send;
    assign out.data  = samples[ch];
    assign out.last  = ch == daq_pkg::CH_W'(daq_pkg::NUM_ADC - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fire_q  <= 1'b0;
            credits <= daq_pkg::CAP_CRED_W'(daq_pkg::BUILDER_DEPTH);
        end else begin
            fire_q <= fire;                             // Strobes seen while busy are lost
            case ({send, out.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            ph      <= '0;
            bit_cnt <= '0;
            ch      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    ph <= '0;
                    if (accept) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    ph <= ph_end ? '0 : ph + 1'b1;      // CS setup of one SCLK period
                    if (ph_end) begin
                        state   <= ST_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                ST_SHIFT: begin
                    ph <= ph_end ? '0 : ph + 1'b1;
                    if (ph_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == daq_pkg::BIT_W'(daq_pkg::SAMPLE_W - 1)) begin
                            state <= ST_SEND;
                            ch    <= '0;
                        end
                    end
                end
                default: begin
                    ch <= ch + 1'b1;
                    if (ch == daq_pkg::CH_W'(daq_pkg::NUM_ADC - 1)) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // MOSI moves on the falling SCLK edge, MISO is taken once the round trip has settled
    always_ff @(posedge clk) begin
        if (accept) begin
            mosi_sr <= daq_pkg::CONV_CMD;
        end else if ((state == ST_SHIFT) && (ph == daq_pkg::PH_W'(daq_pkg::SCLK_HIGH - 1))) begin
            mosi_sr <= {mosi_sr[daq_pkg::SAMPLE_W-2:0], 1'b0};
        end
        if ((state == ST_SHIFT) && (ph == daq_pkg::PH_W'(daq_pkg::MISO_PHASE))) begin
            for (int i = 0; i < daq_pkg::NUM_ADC; i++) begin
                samples[i] <= {samples[i][daq_pkg::SAMPLE_W-2:0], miso[i]};
            end
        end
    end

endmodule

`default_nettype wire

//--- design/frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

module frame_builder (
    input  wire              clk,
    input  wire              rst_n,
    word_credit_if.receiver  in,
    word_credit_if.sender    out
);

    daq_pkg::sample_t                 fifo [daq_pkg::BUILDER_DEPTH];
    logic [daq_pkg::FIFO_AW-1:0]      wr_ptr;
    logic [daq_pkg::FIFO_AW-1:0]      rd_ptr;
    logic [daq_pkg::GROUP_W-1:0]      groups;
    logic [daq_pkg::LINK_CRED_W-1:0]  link_cred;
    logic [daq_pkg::WORD_CNT_W-1:0]   word_idx;
    daq_pkg::seq_t                    seq;
    logic                             active;

    logic group_in;
    logic start;
    logic send;
    logic pop;

    assign group_in = in.valid & in.last;
    assign start    = !active && (groups != '0) && (link_cred != '0);
    assign send     = active && (link_cred != '0);
    assign pop      = send && (word_idx != '0);     // Word 0 is the header

    assign out.valid = send;
    assign out.data  = (word_idx == '0) ? {daq_pkg::SYNC_BYTE, seq} : fifo[rd_ptr];
    assign out.last  = word_idx == daq_pkg::WORD_CNT_W'(daq_pkg::FRAME_WORDS - 1);
    assign in.credit = pop;

    always_ff @(posedge clk) begin
        if (in.valid) begin
            fifo[wr_ptr] <= in.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            groups    <= '0;
            link_cred <= daq_pkg::LINK_CRED_W'(daq_pkg::LINK_BUF_DEPTH);
        end else begin
            if (in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({group_in, start})
                2'b10:   groups <= groups + 1'b1;
                2'b01:   groups <= groups - 1'b1;
                default: groups <= groups;
            endcase
            case ({send, out.credit})
                2'b10:   link_cred <= link_cred - 1'b1;
                2'b01:   link_cred <= link_cred + 1'b1;
                default: link_cred <= link_cred;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            word_idx <= '0;
            seq      <= '0;
        end else if (start) begin
            active   <= 1'b1;
            word_idx <= '0;
        end else if (send) begin
            word_idx <= word_idx + 1'b1;
            if (out.last) begin
                active <= 1'b0;
                seq    <= seq + 1'b1;                   // Only frames that went out use a number
            end
        end
    end

endmodule

`default_nettype wire

//--- design/link_tx.sv
`timescale 1ns/1ps
`default_nettype none

module link_tx (
    input  wire                        clk,
    input  wire                        rst_n,
    word_credit_if.receiver            in,
    output logic [daq_pkg::LANES-1:0]  txd,
    output logic                       txf
);

    daq_pkg::sample_t                  buf_mem [daq_pkg::LINK_BUF_DEPTH];
    logic [daq_pkg::LINK_BUF_DEPTH-1:0] last_mem;
    logic [daq_pkg::LB_AW-1:0]         wr_ptr;
    logic [daq_pkg::LB_AW-1:0]         rd_ptr;
    logic [daq_pkg::LINK_CRED_W-1:0]   count;
    logic [daq_pkg::NIB_CNT_W-1:0]     nib;
    logic [daq_pkg::WORD_CNT_W-1:0]    word_cnt;
    logic                              gap;

    logic sending;
    logic word_done;
    logic frame_done;

    assign sending    = (count != '0) && !gap;
    assign word_done  = sending && (nib == daq_pkg::NIB_CNT_W'(daq_pkg::NIBBLES - 1));
    assign frame_done = word_done &&
                        ((word_cnt == daq_pkg::WORD_CNT_W'(daq_pkg::FRAME_WORDS - 1)) ||
                         last_mem[rd_ptr]);

    assign in.credit = word_done;
    assign txf       = sending;                     // Low for one cycle between frames
    assign txd       = sending ?
                       buf_mem[rd_ptr][(daq_pkg::NIBBLES - 1 - nib) * daq_pkg::LANES +:
                                       daq_pkg::LANES] : '0;

    always_ff @(posedge clk) begin
        if (in.valid) begin
            buf_mem[wr_ptr]  <= in.data;
            last_mem[wr_ptr] <= in.last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            nib      <= '0;
            word_cnt <= '0;
            gap      <= 1'b0;
        end else begin
            if (in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case ({in.valid, word_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (sending) begin
                nib <= nib + 1'b1;                      // MS nibble first
            end
            if (word_done) begin
                rd_ptr   <= rd_ptr + 1'b1;
                word_cnt <= frame_done ? '0 : word_cnt + 1'b1;
            end
            gap <= frame_done;
        end
    end

endmodule

`default_nettype wire

//--- design/daq_top.sv
`timescale 1ns/1ps
`default_nettype none

module daq_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          com_rxf,
    input  wire  [daq_pkg::NUM_ADC-1:0]  adc_miso_p,
    input  wire  [daq_pkg::NUM_ADC-1:0]  adc_miso_n,
    output logic [daq_pkg::LANES-1:0]    com_txd_p,
    output logic [daq_pkg::LANES-1:0]    com_txd_n,
    output logic                         com_txf,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_cs_p,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_cs_n,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_mosi_p,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_mosi_n,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_sclk_p,
    output logic [daq_pkg::NUM_ADC-1:0]  adc_sclk_n
);

    logic                        fire;
    logic [daq_pkg::NUM_ADC-1:0] miso;
    logic [daq_pkg::NUM_ADC-1:0] cs;
    logic [daq_pkg::NUM_ADC-1:0] sclk;
    logic [daq_pkg::NUM_ADC-1:0] mosi;
    logic [daq_pkg::LANES-1:0]   txd;
    logic                        txf;

    word_credit_if cap_to_frm ();
    word_credit_if frm_to_link ();

    pin pin_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .com_txd_p  (com_txd_p),
        .com_txd_n  (com_txd_n),
        .com_rxf    (com_rxf),
        .com_txf    (com_txf),
        .adc_miso_p (adc_miso_p),
        .adc_miso_n (adc_miso_n),
        .adc_cs_p   (adc_cs_p),
        .adc_cs_n   (adc_cs_n),
        .adc_mosi_p (adc_mosi_p),
        .adc_mosi_n (adc_mosi_n),
        .adc_sclk_p (adc_sclk_p),
        .adc_sclk_n (adc_sclk_n),
        .cs         (cs),
        .sclk       (sclk),
        .mosi       (mosi),
        .txd        (txd),
        .txf        (txf),
        .fire       (fire),
        .miso       (miso)
    );

    adc_capture adc_capture_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .fire  (fire),
        .miso  (miso),
        .cs    (cs),
        .sclk  (sclk),
        .mosi  (mosi),
        .out   (cap_to_frm.sender)
    );

    frame_builder frame_builder_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (cap_to_frm.receiver),
        .out   (frm_to_link.sender)
    );

    link_tx link_tx_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (frm_to_link.receiver),
        .txd   (txd),
        .txf   (txf)
    );

endmodule

`default_nettype wire

//--- sim/tb_daq_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_daq_top;

    localparam int MAIN_STROBES   = 12;
    localparam int STRESS_STROBES = 40;
    localparam int CYCLE_LIMIT    = (MAIN_STROBES + STRESS_STROBES) * 200 + 2000;
    localparam int FRAME_CYCLES   = daq_pkg::FRAME_WORDS * daq_pkg::NIBBLES;
    localparam int DRAIN_LIMIT    = 400;              // A round in flight plus the frames queued behind it

    logic                         clk;
    logic                         rst_n;
    logic                         com_rxf;
    wire  [daq_pkg::NUM_ADC-1:0]  adc_miso_p;
    wire  [daq_pkg::NUM_ADC-1:0]  adc_miso_n;
    logic [daq_pkg::LANES-1:0]    com_txd_p;
    logic [daq_pkg::LANES-1:0]    com_txd_n;
    logic                         com_txf;
    logic [daq_pkg::NUM_ADC-1:0]  adc_cs_p;
    logic [daq_pkg::NUM_ADC-1:0]  adc_cs_n;
    logic [daq_pkg::NUM_ADC-1:0]  adc_mosi_p;
    logic [daq_pkg::NUM_ADC-1:0]  adc_mosi_n;
    logic [daq_pkg::NUM_ADC-1:0]  adc_sclk_p;
    logic [daq_pkg::NUM_ADC-1:0]  adc_sclk_n;

    integer           seed          = 52963;
    int               mismatch_errs = 0;
    int               other_errs    = 0;
    int               frames_rx     = 0;
    int               frame_len     = 0;
    int               cycle_cnt;
    int               conv_cnt [daq_pkg::NUM_ADC];   // Falling cs edges seen by each model
    logic             reset_done    = 1'b0;
    daq_pkg::sample_t word_sr;
    daq_pkg::sample_t frame_words [daq_pkg::FRAME_WORDS];

    daq_top daq_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .com_rxf    (com_rxf),
        .adc_miso_p (adc_miso_p),
        .adc_miso_n (adc_miso_n),
        .com_txd_p  (com_txd_p),
        .com_txd_n  (com_txd_n),
        .com_txf    (com_txf),
        .adc_cs_p   (adc_cs_p),
        .adc_cs_n   (adc_cs_n),
        .adc_mosi_p (adc_mosi_p),
        .adc_mosi_n (adc_mosi_n),
        .adc_sclk_p (adc_sclk_p),
        .adc_sclk_n (adc_sclk_n)
    );

    // ########################################
    // Reference model and checks
    // ########################################
    function automatic daq_pkg::sample_t sample_ref(input int channel, input int count);
        return {channel[1:0], count[13:0]};              // Channel on top, conversion count below
    endfunction

    function automatic daq_pkg::sample_t expected_word(input int frame, input int idx);
        if (idx == 0) begin
            return {daq_pkg::SYNC_BYTE, frame[7:0]};
        end
        return sample_ref(idx - 1, frame);
    endfunction

    task automatic check_word(input string name, input daq_pkg::sample_t got,
                              input daq_pkg::sample_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic check_seq(input daq_pkg::seq_t got, input daq_pkg::seq_t exp);
        if (got !== exp) begin
            $display("Mismatch header sequence number: got %h, expected %h", got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic compare_level(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        other_errs++;
    endtask

    task automatic print_counts();
        $display("Frames checked %0d, mismatches %0d, other errors %0d",
                 frames_rx, mismatch_errs, other_errs);
    endtask

    task automatic score_frame();
        if (frame_len != FRAME_CYCLES) begin
            report_error($sformatf("frame %0d kept com_txf high for %0d cycles instead of %0d",
                                   frames_rx, frame_len, FRAME_CYCLES));
        end
        check_seq(frame_words[0][7:0], daq_pkg::seq_t'(frames_rx));
        check_word("header sync byte", frame_words[0] & 16'hFF00,
                   expected_word(frames_rx, 0) & 16'hFF00);
        for (int i = 1; i < daq_pkg::FRAME_WORDS; i++) begin
            check_word($sformatf("frame %0d sample %0d", frames_rx, i - 1),
                       frame_words[i], expected_word(frames_rx, i));
        end
        frames_rx++;
    endtask

    // ########################################
    // ADC models
    // ########################################
    for (genvar c = 0; c < daq_pkg::NUM_ADC; c++) begin : adc_model
        daq_pkg::sample_t shadow;
        daq_pkg::sample_t mosi_cap;
        int               bit_idx;
        int               rises;
        logic             in_round = 1'b0;
        logic             miso_q   = 1'b0;

        assign adc_miso_p[c] = miso_q;
        assign adc_miso_n[c] = ~miso_q;

        always @(negedge adc_cs_p[c]) begin
            shadow      = sample_ref(c, conv_cnt[c]);
            conv_cnt[c] = conv_cnt[c] + 1;
            miso_q     <= shadow[daq_pkg::SAMPLE_W-1];   // MSB waits for the first SCLK
            bit_idx     = 1;
            rises       = 0;
            mosi_cap    = '0;
            in_round    = 1'b1;
        end

        always @(negedge adc_sclk_p[c]) begin
            if (in_round) begin
                miso_q <= (bit_idx < daq_pkg::SAMPLE_W) ?
                          shadow[daq_pkg::SAMPLE_W-1-bit_idx] : 1'b0;
                bit_idx++;
            end
        end

        always @(posedge adc_sclk_p[c]) begin
            if (in_round) begin
                mosi_cap = {mosi_cap[daq_pkg::SAMPLE_W-2:0], adc_mosi_p[c]};
                rises++;
            end
        end

        always @(posedge adc_cs_p[c]) begin
            if (in_round) begin
                in_round = 1'b0;
                if (rises != daq_pkg::SAMPLE_W) begin
                    report_error($sformatf("ADC %0d saw %0d SCLK periods in one round", c, rises));
                end
                check_word($sformatf("adc_mosi_p[%0d] command", c), mosi_cap, daq_pkg::CONV_CMD);
            end
        end
    end

    // ########################################
    // Link receiver and pin checks
    // ########################################
    always @(negedge clk) begin
        if (reset_done) begin
            if (com_txf) begin
                word_sr = {word_sr[daq_pkg::SAMPLE_W-daq_pkg::LANES-1:0], com_txd_p};
                frame_len++;
                if ((frame_len % daq_pkg::NIBBLES == 0) &&
                    (frame_len / daq_pkg::NIBBLES <= daq_pkg::FRAME_WORDS)) begin
                    frame_words[frame_len / daq_pkg::NIBBLES - 1] = word_sr;
                end
            end else if (frame_len != 0) begin
                score_frame();
                frame_len = 0;
            end
        end
    end

    always @(negedge clk) begin
        if (reset_done) begin
            compare_level("com_txd_n", com_txd_n, ~com_txd_p);
            compare_level("adc_cs_n", adc_cs_n, ~adc_cs_p);
            compare_level("adc_sclk_n", adc_sclk_n, ~adc_sclk_p);
            compare_level("adc_mosi_n", adc_mosi_n, ~adc_mosi_p);
        end
    end

    // ########################################
    // Clock, stimulus and timeout
    // ########################################
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fire_strobe(input int width);
        com_rxf <= 1'b1;
        repeat (width) @(posedge clk);
        com_rxf <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        repeat (8) @(posedge clk);                       // Lets the last strobe clear the synchronizer
        while ((frames_rx != conv_cnt[0]) && (waited < DRAIN_LIMIT)) begin
            @(posedge clk);
            waited++;
        end
    endtask

    initial begin
        int gap;
        rst_n   = 1'b1;
        com_rxf = 1'b0;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_done = 1'b1;
        @(negedge clk);
        compare_level("adc_cs_p", adc_cs_p, 4'hF);
        compare_level("adc_sclk_p", adc_sclk_p, 4'h0);
        compare_level("com_txf", {3'b000, com_txf}, 4'h0);
        compare_level("com_txd_p", com_txd_p, 4'h0);
        @(posedge clk);

        for (int i = 0; i < MAIN_STROBES; i++) begin
            fire_strobe(2);
            gap = 100 + ($unsigned($random(seed)) % 60); // Long enough for a whole round
            repeat (gap) @(posedge clk);
        end
        wait_drain();
        if (conv_cnt[0] != MAIN_STROBES) begin
            report_error($sformatf("%0d spaced strobes started %0d conversion rounds",
                                   MAIN_STROBES, conv_cnt[0]));
        end

        for (int i = 0; i < STRESS_STROBES; i++) begin
            fire_strobe(1);
            gap = 1 + ($unsigned($random(seed)) % 16);
            repeat (gap) @(posedge clk);
        end
        wait_drain();
        if (frames_rx != conv_cnt[0]) begin
            report_error($sformatf("%0d frames came out for %0d conversion rounds",
                                   frames_rx, conv_cnt[0]));
        end

        print_counts();
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        report_error($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        print_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- daq.f
design/daq_pkg.sv
design/word_credit_if.sv
design/pin.sv
design/adc_capture.sv
design/frame_builder.sv
design/link_tx.sv
design/daq_top.sv
sim/tb_daq_top.sv

//--- Bender.yml
package:
  name: daq

sources:
  - design/daq_pkg.sv
  - design/word_credit_if.sv
  - design/pin.sv
  - design/adc_capture.sv
  - design/frame_builder.sv
  - design/link_tx.sv
  - design/daq_top.sv
  - target: test
    files:
      - sim/tb_daq_top.sv
